/* flist.f */
verilog/rv_pkg.sv
verilog/fetch_pc.sv
verilog/unified_mem.sv
verilog/decode_ctrl.sv
verilog/reg_file.sv
verilog/execute.sv
verilog/rv_core_top.sv
verif/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f flist.f --top-module rv_core_tb -o rv_core_sim &&
  ./obj_dir/rv_core_sim | tee /dev/stderr | grep -qx "NO ERRORS" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* verif/rv_core_cases.txt */
# t <test name> | p <word index> <instruction> | c <pc> <rd> <wdata> <reg_we>
# numbers in hex; c lines give the commits in order
t alu_ops
p 0 800000B7
p 1 FF000113
p 2 40215193
p 3 00215213
p 4 401103B3
p 5 0021C533
p 6 40A0D6B3
p 7 0FF17713
p 8 001264B3
c 0 1 80000000 1
c 4 2 FFFFFFF0 1
c 8 3 FFFFFFFC 1
c C 4 3FFFFFFC 1
c 10 7 7FFFFFF0 1
c 14 A 0000000C 1
c 18 D FFF80000 1
c 1C E 000000F0 1
c 20 9 BFFFFFFC 1
t x0_and_memory
p 0 00500013
p 1 12345337
p 2 20602023
p 3 20002383
p 4 00038433
c 0 0 00000005 0
c 4 6 12345000 1
c 8 0 12345000 0
c C 7 12345000 1
c 10 8 12345000 1
# taken branches jump over words that are never loaded
t branches
p 0 FFF00093
p 1 00100113
p 2 0020C463
p 4 0020E463
p 5 0020F463
p 7 0020D463
p 8 00208463
p 9 00209463
p B 00210463
p D 00116463
p F 00115463
p 11 00114463
p 12 00117463
p 13 00211463
p 14 00700193
c 0 1 FFFFFFFF 1
c 4 2 00000001 1
c 8 8 FFFFFFFE 0
c 10 8 FFFFFFFE 0
c 14 8 FFFFFFFE 0
c 1C 8 FFFFFFFE 0
c 20 8 FFFFFFFE 0
c 24 8 FFFFFFFE 0
c 2C 8 00000000 0
c 34 8 00000002 0
c 3C 8 00000002 0
c 44 8 00000002 0
c 48 8 00000002 0
c 4C 8 00000000 0
c 50 3 00000007 1

/* verif/rv_core_tb.sv */
`default_nettype none

module rv_core_tb import rv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic    clk = 1'b0;
  logic    rst;
  logic    run;
  logic    load_valid;
  xlen_t   load_addr;
  xlen_t   load_data;
  logic    load_ready;
  logic    commit_valid;
  commit_t commit;

  // records from the cases file, each tagged with its test index
  string   names[$];
  int      prog_test[$];
  xlen_t   prog_addr[$];
  inst_t   prog_word[$];
  int      exp_test[$];
  commit_t exp_commit[$];
  inst_t   image [int]; // program of the current test, by word index

  string   cur_name = "none";
  int      cycles = 0;
  int      limit = 0;
  int      errors = 0;
  int      failed = 0;

  always #4 clk = ~clk;

  rv_core_top #(.mem_words(1024), .reset_pc(32'h0)) dut (
    .clk(clk), .rst(rst), .run(run),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .load_ready(load_ready), .commit_valid(commit_valid), .commit(commit)
  );

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("test %s did not finish within %0d cycles", cur_name, limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // lw and sw only, other widths are outside the kept set
  function automatic bit mem_instruction(input inst_t w);
    return (w[14:12] == 3'b010) && ((w[6:0] == LOAD) || (w[6:0] == STORE));
  endfunction

  function automatic string format_commit(input commit_t c);
    return $sformatf("pc %h rd %0d wdata %h we %b", c.pc, c.rd, c.wdata, c.reg_we);
  endfunction

  task automatic read_cases(output bit ok);
    int        fd;
    int        n;
    string     line;
    xlen_t     a;
    inst_t     w;
    xlen_t     pc;
    reg_addr_t rd;
    xlen_t     wd;
    logic      we;
    commit_t   c;
    ok = 1'b1;
    fd = $fopen("verif/rv_core_cases.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1) begin
          case (line.getc(0))
            "t": names.push_back(line.substr(2, line.len() - 2));
            "p": begin
              n = $sscanf(line, "p %h %h", a, w);
              if (n != 2) ok = 1'b0;
              prog_test.push_back(names.size() - 1);
              prog_addr.push_back(a);
              prog_word.push_back(w);
            end
            "c": begin
              n = $sscanf(line, "c %h %h %h %h", pc, rd, wd, we);
              if (n != 4) ok = 1'b0;
              c.pc     = pc;
              c.rd     = rd;
              c.wdata  = wd;
              c.reg_we = we;
              exp_test.push_back(names.size() - 1);
              exp_commit.push_back(c);
            end
            default: ; // comment lines
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int t);
    commit_t want;
    int      gap;
    int      want_gap;
    int      k;
    int      errs;
    int      idx[$];
    cur_name = names[t];
    errs = 0;
    image.delete();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    foreach (prog_test[i]) begin
      if (prog_test[i] == t) begin
        image[int'(prog_addr[i])] = prog_word[i];
        @(posedge clk);
        load_valid <= 1'b1;
        load_addr  <= prog_addr[i];
        load_data  <= prog_word[i];
        do begin
          @(negedge clk);
          assert (!commit_valid && load_ready) else begin
            $display("%s: core committed or load port was busy while halted", cur_name);
            errs++;
          end
        end while (!load_ready);
      end
    end
    @(posedge clk);
    load_valid <= 1'b0; // last word is taken at this edge
    run        <= 1'b1;
    foreach (exp_test[i]) begin
      if (exp_test[i] == t) idx.push_back(i);
    end
    gap = 0;
    k = 0;
    while (k < idx.size()) begin
      @(negedge clk);
      gap++;
      assert (!load_ready) else begin
        $display("%s: load port ready while the core runs", cur_name);
        errs++;
      end
      if (commit_valid) begin
        want = exp_commit[idx[k]];
        want_gap = 1;
        if (image.exists(int'(want.pc >> 2)) && mem_instruction(image[int'(want.pc >> 2)]))
          want_gap = 2; // lw and sw spend a wait cycle
        assert (commit == want) else begin
          $display("mismatch %s commit %0d: expected %s, actual %s",
                   cur_name, k, format_commit(want), format_commit(commit));
          errs++;
        end
        assert (gap == want_gap) else begin
          $display("%s: commit %0d came %0d cycles after the previous one instead of %0d",
                   cur_name, k, gap, want_gap);
          errs++;
        end
        gap = 0;
        k++;
      end
    end
    @(posedge clk);
    run <= 1'b0;
    errors += errs;
    if (errs != 0) failed++;
    $display("%s: %0d commits checked, %0d errors", cur_name, idx.size(), errs);
  endtask

  initial begin
    bit ok;
    rst        <= 1'b1;
    run        <= 1'b0;
    load_valid <= 1'b0;
    load_addr  <= '0;
    load_data  <= '0;
    read_cases(ok);
    if (ok && names.size() > 0) begin
      limit = 2 * exp_commit.size() + prog_word.size() + 20 * names.size();
      foreach (names[t]) run_test(t);
    end else begin
      errors++;
      $display("cases file missing or malformed");
    end
    $display("%0d tests, %0d failed, %0d errors", names.size(), failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/decode_ctrl.sv */
`default_nettype none

module decode_ctrl import rv_pkg::*; (
  input  wire inst_t inst,
  output reg_addr_t  rs1,
  output reg_addr_t  rs2,
  output reg_addr_t  rd,
  output xlen_t      imm,
  output ctrl_t      ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  always_comb begin
    case (opcode)
      OP_IMM, LOAD: imm = {{20{inst[31]}}, inst[31:20]};
      STORE:        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      BRANCH:       imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      LUI:          imm = {inst[31:12], 12'd0};
      default:      imm = '0;
    endcase
  end

  // anything unmatched leaves ctrl all zero
  always_comb begin
    ctrl = '0;
    case (opcode)
      OP: begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = alu_add;
          10'b0100000_000: ctrl.alu_op = alu_sub;
          10'b0000000_001: ctrl.alu_op = alu_sll;
          10'b0000000_101: ctrl.alu_op = alu_srl;
          10'b0100000_101: ctrl.alu_op = alu_sra;
          10'b0000000_111: ctrl.alu_op = alu_and;
          10'b0000000_110: ctrl.alu_op = alu_or;
          10'b0000000_100: ctrl.alu_op = alu_xor;
          default:         ctrl.reg_write = 1'b0; // slt, sltu and the rest
        endcase
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_op = alu_add;
          3'b100: ctrl.alu_op = alu_xor;
          3'b110: ctrl.alu_op = alu_or;
          3'b111: ctrl.alu_op = alu_and;
          3'b001: begin
            ctrl.alu_op = alu_sll;
            if (funct7 != 7'b0000000) ctrl = '0;
          end
          3'b101: begin
            if (funct7 == 7'b0000000) ctrl.alu_op = alu_srl;
            else if (funct7 == 7'b0100000) ctrl.alu_op = alu_sra;
            else ctrl = '0;
          end
          default: ctrl = '0;
        endcase
      end
      LOAD: begin
        if (funct3 == 3'b010) begin // lw only
          ctrl.use_imm   = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.mem_read  = 1'b1;
        end
      end
      STORE: begin
        if (funct3 == 3'b010) begin // sw only
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      LUI: begin
        ctrl.alu_op    = alu_pass_imm;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      BRANCH: begin
        ctrl.alu_op = alu_sub;
        case (funct3)
          3'b000:  ctrl.branch = br_eq;
          3'b001:  ctrl.branch = br_ne;
          3'b100:  ctrl.branch = br_lt;
          3'b101:  ctrl.branch = br_ge;
          3'b110:  ctrl.branch = br_ltu;
          3'b111:  ctrl.branch = br_geu;
          default: ctrl = '0;
        endcase
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/execute.sv */
`default_nettype none

module execute import rv_pkg::*; (
  input  wire xlen_t     pc,
  input  wire xlen_t     rs1_data,
  input  wire xlen_t     rs2_data,
  input  wire xlen_t     imm,
  input  wire reg_addr_t rd,
  input  wire ctrl_t     ctrl,
  input  wire logic      run,
  input  wire logic      mem_busy,
  input  wire xlen_t     load_data_q,
  output xlen_t          data_addr,
  output xlen_t          store_data,
  output logic           mem_read,
  output logic           mem_write,
  output logic           branch_taken,
  output xlen_t          branch_target,
  output logic           wr_en,
  output reg_addr_t      wr_addr,
  output xlen_t          wr_data,
  output logic           commit_valid,
  output commit_t        commit
);

  xlen_t      op_b;
  logic [4:0] shamt;
  xlen_t      alu_result;
  logic       is_eq, is_lt, is_ltu;

  assign op_b  = ctrl.use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add:      alu_result = rs1_data + op_b;
      alu_sub:      alu_result = rs1_data - op_b;
      alu_sll:      alu_result = rs1_data << shamt;
      alu_srl:      alu_result = rs1_data >> shamt;
      alu_sra:      alu_result = $signed(rs1_data) >>> shamt;
      alu_and:      alu_result = rs1_data & op_b;
      alu_or:       alu_result = rs1_data | op_b;
      alu_xor:      alu_result = rs1_data ^ op_b;
      alu_pass_imm: alu_result = imm;
      default:      alu_result = '0;
    endcase
  end

  // compare registers directly, no flags
  assign is_eq  = (rs1_data == rs2_data);
  assign is_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign is_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.branch)
      br_eq:   branch_taken = is_eq;
      br_ne:   branch_taken = ~is_eq;
      br_lt:   branch_taken = is_lt;
      br_ge:   branch_taken = ~is_lt;
      br_ltu:  branch_taken = is_ltu;
      br_geu:  branch_taken = ~is_ltu;
      default: branch_taken = 1'b0;
    endcase
  end

  assign branch_target = pc + imm;

  assign data_addr  = alu_result;
  assign store_data = rs2_data;
  assign mem_read   = ctrl.mem_read & run;
  assign mem_write  = ctrl.mem_write & run;

  assign wr_addr      = rd;
  assign wr_data      = ctrl.mem_read ? load_data_q : alu_result;
  assign wr_en        = ctrl.reg_write & run & ~mem_busy; // lw writes in the wait cycle
  assign commit_valid = run & ~mem_busy;

  always_comb begin
    commit.pc     = pc;
    commit.rd     = rd;
    commit.wdata  = ctrl.mem_write ? store_data : wr_data;
    commit.reg_we = wr_en & (rd != 5'd0);
  end

endmodule

`default_nettype wire

/* verilog/fetch_pc.sv */
`default_nettype none

module fetch_pc import rv_pkg::*; #(
  parameter xlen_t reset_pc = '0
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  advance,
  input  wire logic  branch_taken,
  input  wire xlen_t branch_target,
  output xlen_t      pc
);

  xlen_t pc_q;
  xlen_t pc_next;

  always_comb begin
    pc_next = pc_q;
    if (advance) begin
      if (branch_taken) begin
        pc_next = branch_target;
      end else begin
        pc_next = pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc_q <= reset_pc;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire reg_addr_t rs1,
  input  wire reg_addr_t rs2,
  output xlen_t          rs1_data,
  output xlen_t          rs2_data,
  input  wire logic      wr_en,
  input  wire reg_addr_t wr_addr,
  input  wire xlen_t     wr_data
);

  xlen_t [31:0] regs;

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (wr_en && (wr_addr != 5'd0)) begin // x0 stays zero
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_core_top.sv */
`default_nettype none

module rv_core_top import rv_pkg::*; #(
  parameter int    mem_words = 1024,
  parameter xlen_t reset_pc  = '0
) (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    run,
  input  wire logic    load_valid,
  input  wire xlen_t   load_addr,
  input  wire xlen_t   load_data,
  output logic         load_ready,
  output logic         commit_valid,
  output commit_t      commit
);

  xlen_t     pc;
  inst_t     inst;
  reg_addr_t rs1, rs2, rd;
  xlen_t     imm;
  ctrl_t     ctrl;
  xlen_t     rs1_data, rs2_data;
  logic      wr_en;
  reg_addr_t wr_addr;
  xlen_t     wr_data;
  xlen_t     data_addr, store_data, load_data_q;
  logic      mem_read, mem_write, mem_busy;
  logic      branch_taken;
  xlen_t     branch_target;
  logic      advance;

  assign advance = run & ~mem_busy; // pc holds during the memory wait

  fetch_pc #(.reset_pc(reset_pc)) u_fetch (
    .clk(clk), .rst(rst), .advance(advance),
    .branch_taken(branch_taken), .branch_target(branch_target), .pc(pc)
  );

  unified_mem #(.mem_words(mem_words)) u_mem (
    .clk(clk), .rst(rst), .run(run), .pc(pc), .inst(inst),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .load_ready(load_ready), .data_addr(data_addr), .store_data(store_data),
    .mem_read(mem_read), .mem_write(mem_write),
    .load_data_q(load_data_q), .mem_busy(mem_busy)
  );

  decode_ctrl u_decode (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .ctrl(ctrl)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  execute u_exec (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .rd(rd),
    .ctrl(ctrl), .run(run), .mem_busy(mem_busy), .load_data_q(load_data_q),
    .data_addr(data_addr), .store_data(store_data),
    .mem_read(mem_read), .mem_write(mem_write),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .commit_valid(commit_valid), .commit(commit)
  );

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_srl      = 4'd3,
    alu_sra      = 4'd4,
    alu_and      = 4'd5,
    alu_or       = 4'd6,
    alu_xor      = 4'd7,
    alu_pass_imm = 4'd8
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_eq   = 3'd1,
    br_ne   = 3'd2,
    br_lt   = 3'd3,
    br_ge   = 3'd4,
    br_ltu  = 3'd5,
    br_geu  = 3'd6
  } branch_e;

  typedef struct packed {
    alu_op_e alu_op;
    branch_e branch;
    logic    use_imm;   // operand b is imm, not rs2
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
  } ctrl_t;

  // one record per finished instruction
  typedef struct packed {
    xlen_t     pc;
    reg_addr_t rd;
    xlen_t     wdata;
    logic      reg_we;
  } commit_t;

endpackage

`default_nettype wire

/* verilog/unified_mem.sv */
`default_nettype none

module unified_mem import rv_pkg::*; #(
  parameter int mem_words = 1024
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  run,
  input  wire xlen_t pc,
  output inst_t      inst,
  input  wire logic  load_valid,
  input  wire xlen_t load_addr,
  input  wire xlen_t load_data,
  output logic       load_ready,
  input  wire xlen_t data_addr,
  input  wire xlen_t store_data,
  input  wire logic  mem_read,
  input  wire logic  mem_write,
  output xlen_t      load_data_q,
  output logic       mem_busy
);

  localparam int idx_w = $clog2(mem_words);

  typedef enum logic {mem_idle, mem_wait} mem_state_e;

  xlen_t            mem [mem_words];
  mem_state_e       state, state_next;
  logic [idx_w-1:0] data_idx, wr_idx;
  logic             wr_en;
  xlen_t            wr_word;

  assign inst     = mem[pc[idx_w+1:2]];
  assign data_idx = data_addr[idx_w+1:2];

  assign load_ready = ~run; // loading only while halted
  assign mem_busy   = (state == mem_idle) && (mem_read || mem_write);
  assign state_next = mem_busy ? mem_wait : mem_idle;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= mem_idle;
    end else begin
      state <= state_next;
    end
  end

  // program load and sw never overlap
  always_comb begin
    wr_en   = 1'b0;
    wr_idx  = data_idx;
    wr_word = store_data;
    if (load_valid && load_ready) begin
      wr_en   = 1'b1;
      wr_idx  = load_addr[idx_w-1:0];
      wr_word = load_data;
    end else if (mem_busy && mem_write) begin
      wr_en = 1'b1; // store lands in the first cycle
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_word;
    end
    load_data_q <= mem[data_idx];
  end

endmodule

`default_nettype wire
